// File: rtl/uart_reg_pkg.sv
package uart_reg_pkg;

    localparam logic [31:0] base_addr = 32'h1000_0000;

    // register offsets from base_addr
    localparam logic [31:0] ctrl_ofs         = 32'h00;
    localparam logic [31:0] clk_div_ofs      = 32'h04;
    localparam logic [31:0] tx_fifo_ctrl_ofs = 32'h20;
    localparam logic [31:0] rx_fifo_ctrl_ofs = 32'h24;
    localparam logic [31:0] tx_status_ofs    = 32'h40;
    localparam logic [31:0] rx_status_ofs    = 32'h44;
    localparam logic [31:0] tx_data_ofs      = 32'h80;
    localparam logic [31:0] rx_data_ofs      = 32'h84;

    localparam int tx_en_bit = 0;
    localparam int rx_en_bit = 1;

    localparam int frac_lsb = 0;   // clk_div fields
    localparam int frac_w   = 4;
    localparam int int_lsb  = 16;
    localparam int int_w    = 16;

    localparam int wm_lsb   = 0;   // fifo control fields
    localparam int flow_lsb = 8;
    localparam int run_bit  = 31;  // low holds the fifo empty

    localparam int fill_lsb  = 0;  // status word fields
    localparam int empty_bit = 8;
    localparam int full_bit  = 9;
    localparam int wm_bit    = 10;
    localparam int udf_bit   = 11;
    localparam int ovf_bit   = 12;
    localparam int shift_bit = 16; // tx idle or rx byte ready
    localparam int brk_bit   = 20;

    localparam int fifo_depth = 16;
    localparam int fifo_aw    = 5;  // fill count holds 0..16

    localparam logic [31:0] ctrl_rst         = 32'h0;
    localparam logic [31:0] clk_div_rst      = (32'd208 << int_lsb) | (32'd5 << frac_lsb);
    localparam logic [31:0] tx_fifo_ctrl_rst = (32'd1 << run_bit) | (32'd8 << wm_lsb);
    localparam logic [31:0] rx_fifo_ctrl_rst = (32'd1 << run_bit) | (32'd14 << flow_lsb) |
                                               (32'd8 << wm_lsb);

    typedef struct packed {
        logic [31:0] paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic              tx_en;
        logic              rx_en;
        logic [int_w-1:0]  int_div;
        logic [frac_w-1:0] frac_div;
        logic              tx_fifo_run;
        logic              rx_fifo_run;
    } uart_cfg_t;

endpackage

// File: rtl/uart_frame_pkg.sv
package uart_frame_pkg;

    localparam int data_bits = 8;  // 8N1, lsb first
    localparam int os_rate   = 16; // ticks per bit
    localparam int os_mid    = 8;  // start bit recheck point

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_e;

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_e;

    typedef struct packed {
        logic [uart_reg_pkg::fifo_aw-1:0] fill;
        logic                             empty;
        logic                             full;
        logic                             overflow;  // sticky until run drops
        logic                             underflow; // sticky until run drops
    } fifo_stat_t;

endpackage

// File: rtl/uart_apb_regs.sv
`timescale 1ns/10ps

module uart_apb_regs (
    input  logic                       uart_clk,
    input  logic                       PRESETn,
    input  uart_reg_pkg::apb_req_t     req,
    output logic [31:0]                prdata,
    output uart_reg_pkg::uart_cfg_t    cfg,
    output logic                       tx_push,
    output logic [7:0]                 tx_wdata,
    output logic                       rx_pop,
    input  logic [7:0]                 rx_rdata,
    input  uart_frame_pkg::fifo_stat_t tx_stat,
    input  uart_frame_pkg::fifo_stat_t rx_stat,
    input  logic                       tx_idle,
    input  logic                       rx_ready,
    input  logic                       rx_break,
    output logic                       rts_n
);
    import uart_reg_pkg::*;

    logic [31:0]        ctrl_q;
    logic [31:0]        clk_div_q;
    logic [31:0]        tx_fifo_ctrl_q;
    logic [31:0]        rx_fifo_ctrl_q;
    logic [31:0]        tx_status;
    logic [31:0]        rx_status;
    logic               wr_en;
    logic               rd_en;
    logic               tx_wm;
    logic               rx_wm;

    // common part of both status words
    function automatic logic [31:0] stat_word(uart_frame_pkg::fifo_stat_t s, logic wm);
        logic [31:0] w;
        w = '0;
        w[fill_lsb +: fifo_aw] = s.fill;
        w[empty_bit] = s.empty;
        w[full_bit]  = s.full;
        w[wm_bit]    = wm;
        w[udf_bit]   = s.underflow;
        w[ovf_bit]   = s.overflow;
        return w;
    endfunction

    assign wr_en = req.psel && req.penable && req.pwrite;  // access phase only
    assign rd_en = req.psel && req.penable && !req.pwrite;

    assign tx_push  = wr_en && (req.paddr == base_addr + tx_data_ofs);
    assign tx_wdata = req.pwdata[7:0];
    assign rx_pop   = rd_en && (req.paddr == base_addr + rx_data_ofs);

    always_ff @(posedge uart_clk or negedge PRESETn) begin
        if (!PRESETn) begin
            ctrl_q         <= ctrl_rst;
            clk_div_q      <= clk_div_rst;
            tx_fifo_ctrl_q <= tx_fifo_ctrl_rst;
            rx_fifo_ctrl_q <= rx_fifo_ctrl_rst;
        end else if (wr_en) begin
            case (req.paddr)
                base_addr + ctrl_ofs:         ctrl_q         <= req.pwdata;
                base_addr + clk_div_ofs:      clk_div_q      <= req.pwdata;
                base_addr + tx_fifo_ctrl_ofs: tx_fifo_ctrl_q <= req.pwdata;
                base_addr + rx_fifo_ctrl_ofs: rx_fifo_ctrl_q <= req.pwdata;
                default: ;  // tx_data goes to the fifo
            endcase
        end
    end

    always_comb begin
        cfg.tx_en       = ctrl_q[tx_en_bit];
        cfg.rx_en       = ctrl_q[rx_en_bit];
        cfg.int_div     = clk_div_q[int_lsb +: int_w];
        cfg.frac_div    = clk_div_q[frac_lsb +: frac_w];
        cfg.tx_fifo_run = tx_fifo_ctrl_q[run_bit];
        cfg.rx_fifo_run = rx_fifo_ctrl_q[run_bit];
    end

    assign tx_wm = tx_stat.fill >= tx_fifo_ctrl_q[wm_lsb +: fifo_aw];
    assign rx_wm = rx_stat.fill >= rx_fifo_ctrl_q[wm_lsb +: fifo_aw];
    assign rts_n = rx_stat.fill >= rx_fifo_ctrl_q[flow_lsb +: fifo_aw];  // ask peer to pause

    always_comb begin
        tx_status = stat_word(tx_stat, tx_wm);
        tx_status[shift_bit] = tx_idle;
        rx_status = stat_word(rx_stat, rx_wm);
        rx_status[shift_bit] = rx_ready;
        rx_status[brk_bit]   = rx_break;
    end

    always_comb begin
        prdata = '0;
        if (rd_en) begin
            case (req.paddr)
                base_addr + ctrl_ofs:         prdata = ctrl_q;
                base_addr + clk_div_ofs:      prdata = clk_div_q;
                base_addr + tx_fifo_ctrl_ofs: prdata = tx_fifo_ctrl_q;
                base_addr + rx_fifo_ctrl_ofs: prdata = rx_fifo_ctrl_q;
                base_addr + tx_status_ofs:    prdata = tx_status;
                base_addr + rx_status_ofs:    prdata = rx_status;
                base_addr + rx_data_ofs:      prdata = {24'h0, rx_rdata};  // fifo head, popped
                default:                      prdata = '0;
            endcase
        end
    end

    // the two fifos are never touched by the bus in one cycle
    a_push_pop_excl: assert property (@(posedge uart_clk) disable iff (!PRESETn)
        !(tx_push && rx_pop));

endmodule

// File: rtl/uart_baud_gen.sv
`timescale 1ns/10ps

module uart_baud_gen (
    input  logic        uart_clk,
    input  logic        PRESETn,
    input  logic [15:0] int_div,
    input  logic [3:0]  frac_div,
    output logic        os_tick
);

    logic [15:0] cnt;
    logic [3:0]  acc;      // fractional accumulator
    logic [4:0]  acc_sum;

    assign acc_sum = {1'b0, acc} + {1'b0, frac_div};

    // interval is int_div cycles, plus one whenever the accumulator carries
    always_ff @(posedge uart_clk or negedge PRESETn) begin
        if (!PRESETn) begin
            cnt     <= '0;
            acc     <= '0;
            os_tick <= 1'b0;
        end else if (int_div < 16'd2) begin
            cnt     <= '0;  // divider stopped
            acc     <= '0;
            os_tick <= 1'b0;
        end else if (cnt == 16'd0) begin
            os_tick <= 1'b1;
            acc     <= acc_sum[3:0];
            cnt     <= int_div - 16'd1 + {15'd0, acc_sum[4]};
        end else begin
            os_tick <= 1'b0;
            cnt     <= cnt - 16'd1;
        end
    end

    a_tick_single: assert property (@(posedge uart_clk) disable iff (!PRESETn)
        os_tick |=> !os_tick);

endmodule

// File: rtl/uart_sync_fifo.sv
`timescale 1ns/10ps

module uart_sync_fifo #(
    parameter int width = 8
) (
    input  logic                       uart_clk,
    input  logic                       PRESETn,
    input  logic                       run,
    input  logic                       push,
    input  logic [width-1:0]           wdata,
    input  logic                       pop,
    output logic [width-1:0]           rdata,
    output uart_frame_pkg::fifo_stat_t stat
);
    import uart_reg_pkg::*;

    logic [width-1:0]   mem [fifo_depth];
    logic [fifo_aw-2:0] wr_ptr;
    logic [fifo_aw-2:0] rd_ptr;
    logic [fifo_aw-1:0] fill;
    logic               ovf_q;
    logic               udf_q;
    logic               empty;
    logic               full;
    logic               do_push;
    logic               do_pop;

    assign empty   = (fill == '0);
    assign full    = (fill == fifo_aw'(fifo_depth));
    assign do_pop  = run && pop && !empty;
    assign do_push = run && push && (!full || do_pop);  // full push ok with a pop

    always_ff @(posedge uart_clk or negedge PRESETn) begin
        if (!PRESETn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
            ovf_q  <= 1'b0;
            udf_q  <= 1'b0;
        end else if (!run) begin
            wr_ptr <= '0;  // soft reset
            rd_ptr <= '0;
            fill   <= '0;
            ovf_q  <= 1'b0;
            udf_q  <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            fill  <= fill + fifo_aw'(do_push) - fifo_aw'(do_pop);
            ovf_q <= ovf_q | (push && !do_push);  // byte dropped
            udf_q <= udf_q | (pop && empty);
        end
    end

    always_ff @(posedge uart_clk) begin
        if (do_push) mem[wr_ptr] <= wdata;
    end

    assign rdata = empty ? '0 : mem[rd_ptr];  // fall-through head

    always_comb begin
        stat.fill      = fill;
        stat.empty     = empty;
        stat.full      = full;
        stat.overflow  = ovf_q;
        stat.underflow = udf_q;
    end

    a_fill_bound: assert property (@(posedge uart_clk) disable iff (!PRESETn)
        fill <= fifo_aw'(fifo_depth));

endmodule

// File: rtl/uart_tx_shift.sv
`timescale 1ns/10ps

module uart_tx_shift (
    input  logic       uart_clk,
    input  logic       PRESETn,
    input  logic       os_tick,
    input  logic       tx_en,
    input  logic       fifo_empty,
    input  logic [7:0] fifo_data,
    output logic       pop,
    output logic       tx,
    output logic       idle
);
    import uart_frame_pkg::*;

    tx_state_e            state;
    logic [3:0]           tick_cnt;
    logic [2:0]           bit_idx;
    logic [data_bits-1:0] shreg;
    logic                 bit_end;

    assign idle    = (state == tx_idle);
    assign pop     = idle && tx_en && !fifo_empty;
    assign bit_end = os_tick && (tick_cnt == 4'(os_rate - 1));

    always_ff @(posedge uart_clk) begin
        if (pop) shreg <= fifo_data;  // head loads as it is popped
    end

    always_ff @(posedge uart_clk or negedge PRESETn) begin
        if (!PRESETn) begin
            state    <= tx_idle;
            tick_cnt <= '0;
            bit_idx  <= '0;
            tx       <= 1'b1;
        end else begin
            if (pop) tick_cnt <= '0;
            else if (os_tick && !idle) tick_cnt <= tick_cnt + 1'b1;  // wraps per bit
            case (state)
                tx_idle: if (pop) begin
                    state <= tx_start;
                    tx    <= 1'b0;
                end
                tx_start: if (bit_end) begin
                    state   <= tx_data;
                    bit_idx <= '0;
                    tx      <= shreg[0];
                end
                tx_data: if (bit_end) begin
                    if (bit_idx == 3'(data_bits - 1)) begin
                        state <= tx_stop;
                        tx    <= 1'b1;
                    end else begin
                        bit_idx <= bit_idx + 1'b1;
                        tx      <= shreg[bit_idx + 1'b1];
                    end
                end
                tx_stop: if (bit_end) state <= tx_idle;
                default: state <= tx_idle;
            endcase
        end
    end

endmodule

// File: rtl/uart_rx_shift.sv
`timescale 1ns/10ps

module uart_rx_shift (
    input  logic       uart_clk,
    input  logic       PRESETn,
    input  logic       os_tick,
    input  logic       rx_en,
    input  logic       rx,
    output logic       push,
    output logic [7:0] rx_data,
    output logic       ready,
    output logic       brk
);
    import uart_frame_pkg::*;

    rx_state_e            state;
    logic [1:0]           sync_q;   // two flop synchronizer
    logic                 rx_s;
    logic [3:0]           tick_cnt;
    logic [2:0]           bit_idx;
    logic [data_bits-1:0] shreg;
    logic                 mid_start;
    logic                 bit_end;

    assign rx_s      = sync_q[1];
    assign mid_start = os_tick && (tick_cnt == 4'(os_mid - 1));
    assign bit_end   = os_tick && (tick_cnt == 4'(os_rate - 1));  // middle of next bit
    assign rx_data   = shreg;

    always_ff @(posedge uart_clk) begin
        if (state == uart_frame_pkg::rx_data && bit_end) shreg[bit_idx] <= rx_s;
    end

    always_ff @(posedge uart_clk or negedge PRESETn) begin
        if (!PRESETn) begin
            sync_q   <= 2'b11;  // line idles high
            state    <= rx_idle;
            tick_cnt <= '0;
            bit_idx  <= '0;
            push     <= 1'b0;
            ready    <= 1'b0;
            brk      <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], rx};
            push   <= 1'b0;
            if (state == rx_idle) tick_cnt <= '0;
            else if (os_tick) tick_cnt <= tick_cnt + 1'b1;
            case (state)
                rx_idle: if (rx_en && !rx_s) begin
                    state <= rx_start;
                    ready <= 1'b0;
                end
                rx_start: if (mid_start) begin
                    tick_cnt <= '0;
                    bit_idx  <= '0;
                    state    <= rx_s ? rx_idle : uart_frame_pkg::rx_data;  // false start
                end
                uart_frame_pkg::rx_data: if (bit_end) begin
                    if (bit_idx == 3'(data_bits - 1)) state <= rx_stop;
                    else bit_idx <= bit_idx + 1'b1;
                end
                rx_stop: if (bit_end) begin
                    state <= rx_idle;
                    if (rx_s) begin
                        push  <= 1'b1;
                        ready <= 1'b1;
                        brk   <= 1'b0;
                    end else if (shreg == '0) begin
                        brk <= 1'b1;  // line held low for a whole frame
                    end
                end
                default: state <= rx_idle;
            endcase
            if (!rx_en) state <= rx_idle;  // abort on disable
        end
    end

endmodule

// File: rtl/uart_apb_top.sv
`timescale 1ns/10ps

module uart_apb_top (
    input  logic        uart_clk,
    input  logic        PRESETn,
    input  logic [31:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    input  logic        rx,
    output logic        tx,
    output logic        rts_n
);
    import uart_reg_pkg::*;
    import uart_frame_pkg::*;

    apb_req_t             req;
    uart_cfg_t            cfg;
    fifo_stat_t           tx_stat;
    fifo_stat_t           rx_stat;
    logic                 os_tick;
    logic                 tx_push;
    logic                 tx_pop;
    logic                 rx_push;
    logic                 rx_pop;
    logic [7:0]           tx_wdata;
    logic [7:0]           tx_head;
    logic [7:0]           rx_byte;
    logic [7:0]           rx_head;
    logic                 tx_shift_idle;
    logic                 rx_ready;
    logic                 rx_break;

    assign req = '{paddr: paddr, psel: psel, penable: penable, pwrite: pwrite, pwdata: pwdata};

    uart_apb_regs uart_apb_regs_i (
        .uart_clk, .PRESETn, .req, .prdata, .cfg,
        .tx_push, .tx_wdata, .rx_pop, .rx_rdata(rx_head),
        .tx_stat, .rx_stat, .tx_idle(tx_shift_idle), .rx_ready, .rx_break, .rts_n
    );

    uart_baud_gen uart_baud_gen_i (
        .uart_clk, .PRESETn, .int_div(cfg.int_div), .frac_div(cfg.frac_div), .os_tick
    );

    uart_sync_fifo #(.width(data_bits)) tx_fifo_i (
        .uart_clk, .PRESETn, .run(cfg.tx_fifo_run), .push(tx_push), .wdata(tx_wdata),
        .pop(tx_pop), .rdata(tx_head), .stat(tx_stat)
    );

    uart_sync_fifo #(.width(data_bits)) rx_fifo_i (
        .uart_clk, .PRESETn, .run(cfg.rx_fifo_run), .push(rx_push), .wdata(rx_byte),
        .pop(rx_pop), .rdata(rx_head), .stat(rx_stat)
    );

    uart_tx_shift uart_tx_shift_i (
        .uart_clk, .PRESETn, .os_tick, .tx_en(cfg.tx_en), .fifo_empty(tx_stat.empty),
        .fifo_data(tx_head), .pop(tx_pop), .tx, .idle(tx_shift_idle)
    );

    uart_rx_shift uart_rx_shift_i (
        .uart_clk, .PRESETn, .os_tick, .rx_en(cfg.rx_en), .rx, .push(rx_push),
        .rx_data(rx_byte), .ready(rx_ready), .brk(rx_break)
    );

endmodule

// File: bench/uart_apb_tb.sv
`timescale 1ns/10ps

module uart_apb_tb;
    import uart_reg_pkg::*;

    typedef enum {op_wr, op_rd, op_wait, op_low, op_rts, op_tx} op_e;

    localparam time clk_period = 100;
    localparam int  wait_tries = 5000;  // status polls before giving up
    localparam logic [31:0] fill_mask = 32'h1f;

    logic        uart_clk;
    logic        PRESETn;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        rx;
    logic        tx;
    logic        rts_n;
    logic        hold_low;

    // stimulus table, one entry per test row
    string       names[$];
    op_e         ops[$];
    logic [31:0] addrs[$];
    logic [31:0] datas[$];  // write data, read mask, or hold cycles
    logic [31:0] exps[$];
    integer      seed;
    int          pass_cnt;
    int          fail_cnt;
    int          row_errs;

    assign rx = hold_low ? 1'b0 : tx;  // loopback unless forcing a break

    uart_apb_top uart_apb_top_i (
        .uart_clk, .PRESETn, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata,
        .rx, .tx, .rts_n
    );

    initial begin
        uart_clk = 1'b0;
        forever #(clk_period / 2) uart_clk = ~uart_clk;
    end

    task automatic add_row(input string name, input op_e op, input logic [31:0] addr,
                           input logic [31:0] data, input logic [31:0] exp);
        names.push_back(name);
        ops.push_back(op);
        addrs.push_back(addr);
        datas.push_back(data);
        exps.push_back(exp);
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            row_errs++;
        end
    endtask

    // both bus tasks start and end on a falling edge
    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge uart_clk);
        penable = 1'b1;  // access phase, write lands on the next rising edge
        @(negedge uart_clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge uart_clk);
        penable = 1'b1;
        #(clk_period / 4) data = prdata;  // settled mid low phase
        @(negedge uart_clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic poll_status(input string name, input logic [31:0] addr,
                               input logic [31:0] mask, input logic [31:0] exp);
        logic [31:0] val;
        int          tries;
        tries = 0;
        apb_read(addr, val);
        while ((val & mask) !== exp && tries < wait_tries) begin
            apb_read(addr, val);
            tries++;
        end
        if ((val & mask) !== exp) begin
            $display("timeout waiting for %s to reach 0x%08h under mask 0x%08h",
                     name, exp, mask);
            row_errs++;
        end
    endtask

    task automatic build_table;
        logic [7:0] sent[$];
        logic [7:0] b;
        add_row("rst_ctrl", op_rd, base_addr + ctrl_ofs, 32'hffff_ffff, ctrl_rst);
        add_row("rst_clk_div", op_rd, base_addr + clk_div_ofs, 32'hffff_ffff, clk_div_rst);
        add_row("rst_tx_fifo_ctrl", op_rd, base_addr + tx_fifo_ctrl_ofs, 32'hffff_ffff,
                tx_fifo_ctrl_rst);
        add_row("rst_rx_fifo_ctrl", op_rd, base_addr + rx_fifo_ctrl_ofs, 32'hffff_ffff,
                rx_fifo_ctrl_rst);
        add_row("rst_tx_status", op_rd, base_addr + tx_status_ofs,
                fill_mask | (32'd1 << empty_bit) | (32'd1 << shift_bit),
                (32'd1 << empty_bit) | (32'd1 << shift_bit));
        add_row("rst_rts_n", op_rts, 32'h0, 32'h0, 32'h0);
        add_row("rst_tx_line", op_tx, 32'h0, 32'h0, 32'h1);  // line idles high

        // loopback at 4 cycles per tick
        add_row("lb_clk_div", op_wr, base_addr + clk_div_ofs, 32'd4 << int_lsb, 32'h0);
        add_row("lb_ctrl", op_wr, base_addr + ctrl_ofs, 32'h3, 32'h0);
        for (int i = 0; i < 4; i++) begin
            b = $random(seed);
            sent.push_back(b);
            add_row($sformatf("lb_tx%0d", i), op_wr, base_addr + tx_data_ofs, {24'h0, b}, 32'h0);
        end
        add_row("lb_fill4", op_wait, base_addr + rx_status_ofs, fill_mask, 32'd4);
        for (int i = 0; i < 4; i++)
            add_row($sformatf("lb_rx%0d", i), op_rd, base_addr + rx_data_ofs, 32'hff,
                    {24'h0, sent[i]});
        add_row("lb_empty", op_rd, base_addr + rx_status_ofs,
                fill_mask | (32'd1 << empty_bit), 32'd1 << empty_bit);

        // tx shifter off so the fifo overfills
        add_row("ovf_ctrl", op_wr, base_addr + ctrl_ofs, 32'd1 << rx_en_bit, 32'h0);
        for (int i = 0; i < 17; i++)
            add_row($sformatf("ovf_tx%0d", i), op_wr, base_addr + tx_data_ofs,
                    $random(seed) & 32'hff, 32'h0);
        add_row("ovf_status", op_rd, base_addr + tx_status_ofs,
                fill_mask | (32'd1 << full_bit) | (32'd1 << wm_bit) | (32'd1 << ovf_bit),
                32'd16 | (32'd1 << full_bit) | (32'd1 << wm_bit) | (32'd1 << ovf_bit));
        add_row("ovf_stop", op_wr, base_addr + tx_fifo_ctrl_ofs,
                tx_fifo_ctrl_rst & ~(32'd1 << run_bit), 32'h0);
        add_row("ovf_run", op_wr, base_addr + tx_fifo_ctrl_ofs, tx_fifo_ctrl_rst, 32'h0);
        add_row("ovf_clear", op_rd, base_addr + tx_status_ofs,
                fill_mask | (32'd1 << empty_bit) | (32'd1 << ovf_bit), 32'd1 << empty_bit);

        add_row("udf_read", op_rd, base_addr + rx_data_ofs, 32'hffff_ffff, 32'h0);
        add_row("udf_status", op_rd, base_addr + rx_status_ofs, 32'd1 << udf_bit,
                32'd1 << udf_bit);

        // flow control at three bytes
        sent.delete();
        add_row("flow_thresh", op_wr, base_addr + rx_fifo_ctrl_ofs,
                (32'd1 << run_bit) | (32'd3 << flow_lsb) | (32'd8 << wm_lsb), 32'h0);
        add_row("flow_ctrl", op_wr, base_addr + ctrl_ofs, 32'h3, 32'h0);
        for (int i = 0; i < 3; i++) begin
            b = $random(seed);
            sent.push_back(b);
            add_row($sformatf("flow_tx%0d", i), op_wr, base_addr + tx_data_ofs, {24'h0, b},
                    32'h0);
        end
        add_row("flow_fill3", op_wait, base_addr + rx_status_ofs, fill_mask, 32'd3);
        add_row("flow_rts_high", op_rts, 32'h0, 32'h0, 32'h1);
        add_row("flow_rx0", op_rd, base_addr + rx_data_ofs, 32'hff, {24'h0, sent[0]});
        add_row("flow_rts_low", op_rts, 32'h0, 32'h0, 32'h0);

        // line stays low to the end, a release mid frame would push a byte
        add_row("brk_hold", op_low, 32'h0, 32'd1500, 32'h0);
        add_row("brk_status", op_rd, base_addr + rx_status_ofs,
                fill_mask | (32'd1 << brk_bit), 32'd2 | (32'd1 << brk_bit));
    endtask

    task automatic run_row(input int r);
        logic [31:0] val;
        case (ops[r])
            op_wr: apb_write(addrs[r], datas[r]);
            op_rd: begin
                apb_read(addrs[r], val);
                check_val(names[r], exps[r], val & datas[r]);
            end
            op_wait: poll_status(names[r], addrs[r], datas[r], exps[r]);
            op_low: begin
                hold_low = 1'b1;
                repeat (datas[r]) @(negedge uart_clk);
            end
            op_rts: check_val(names[r], exps[r], {31'h0, rts_n});
            op_tx: check_val(names[r], exps[r], {31'h0, tx});
            default: begin
                $display("unknown operation in row %0d", r);
                row_errs++;
            end
        endcase
    endtask

    initial begin
        PRESETn  = 1'b0;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = '0;
        hold_low = 1'b0;
        seed     = 20946;
        pass_cnt = 0;
        fail_cnt = 0;
        build_table();
        repeat (3) @(negedge uart_clk);
        PRESETn = 1'b1;
        @(negedge uart_clk);
        for (int r = 0; r < names.size(); r++) begin
            row_errs = 0;
            run_row(r);
            if (row_errs == 0) begin
                pass_cnt++;
                $display("test %s: pass", names[r]);
            end else begin
                fail_cnt++;
                $display("test %s: fail", names[r]);
            end
        end
        $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: flist.f
rtl/uart_reg_pkg.sv
rtl/uart_frame_pkg.sv
rtl/uart_apb_regs.sv
rtl/uart_baud_gen.sv
rtl/uart_sync_fifo.sv
rtl/uart_tx_shift.sv
rtl/uart_rx_shift.sv
rtl/uart_apb_top.sv
bench/uart_apb_tb.sv
